/* hw/cpu_defs.svh */
// CPU width definitions
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// 16-bit machine, word addressed

// data word and register width
`define BITS 16

// memory and port address width
`define ADDRESS_BITS 16

// register select, 16 registers
`define REGISTER_BITS 4

`endif

/* hw/cpu_pkg.sv */
// CPU shared types
`include "cpu_defs.svh"

package cpu_pkg;

	// instruction bits 15..12, codes 13 and 14 decode as nop
	typedef enum logic [3:0] {
		OP_NOP  = 4'd0,
		OP_LDI  = 4'd1,
		OP_ADD  = 4'd2,
		OP_SUB  = 4'd3,
		OP_AND  = 4'd4,
		OP_OR   = 4'd5,
		OP_XOR  = 4'd6,
		OP_SHR  = 4'd7,
		OP_IN   = 4'd8,
		OP_OUT  = 4'd9,
		OP_JMP  = 4'd10,
		OP_JZ   = 4'd11,
		OP_JC   = 4'd12,
		OP_HALT = 4'd15
	} cpu_opcode_e;

	typedef enum logic [2:0] {
		ALU_PASS,
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHR
	} alu_op_e;

	typedef enum logic [1:0] {
		FETCH,
		WAIT_EXEC,
		HALTED
	} fetch_state_e;

	typedef struct packed {
		cpu_opcode_e               op;
		logic [`REGISTER_BITS-1:0] rd;
		logic [`REGISTER_BITS-1:0] ra;
		logic [`REGISTER_BITS-1:0] rb;     // holds rd for OUT
		logic [7:0]                imm8;
		alu_op_e                   alu_op;
		logic                      writes_reg;
		logic                      sets_flags;
		logic                      is_port;
	} cpu_instr_t;

	typedef struct packed {
		logic z;
		logic c;
		logic s;
		logic v;
	} alu_flags_t;

	typedef struct packed {
		logic                      rd;
		logic                      wr;
		logic [`ADDRESS_BITS-1:0]  address;
		logic [`BITS-1:0]          data;
	} port_req_t;

endpackage

/* hw/cpu_fetch.sv */
// Instruction fetch unit
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_fetch import cpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,

	output logic [`ADDRESS_BITS-1:0] memory_address,
	input  logic [`BITS-1:0]         memory_in,
	output logic                     memory_valid,   // request to memory
	input  logic                     memory_ready,   // word available

	output logic                     instr_valid,    // one-cycle strobe
	output logic [`BITS-1:0]         instr_word,

	input  logic                     exec_done,
	input  logic                     load_pc,
	input  logic [`ADDRESS_BITS-1:0] new_pc,
	input  logic                     halt,
	output logic                     halted
);

	fetch_state_e             state;
	logic [`ADDRESS_BITS-1:0] pc;    // word address
	logic                     accept;

	assign accept = (state == FETCH) && memory_valid && memory_ready;
	assign memory_address = pc;      // held stable while waiting
	assign halted = (state == HALTED);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= FETCH;
			pc <= '0;
			memory_valid <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			instr_valid <= 1'b0;
			case (state)
				FETCH: begin
					if (accept) begin
						memory_valid <= 1'b0;
						instr_valid <= 1'b1;
						state <= WAIT_EXEC;
					end else begin
						memory_valid <= 1'b1;   // raise or hold request
					end
				end
				WAIT_EXEC: begin
					if (halt) begin
						state <= HALTED;
					end else if (exec_done) begin
						pc <= load_pc ? new_pc : pc + 1'b1;
						memory_valid <= 1'b1;   // next request right away
						state <= FETCH;
					end
				end
				HALTED: state <= HALTED;   // only reset leaves
				default: state <= FETCH;
			endcase
		end
	end

	// instruction register
	always_ff @(posedge clk) begin
		if (accept)
			instr_word <= memory_in;
	end

endmodule

/* hw/cpu_decode.sv */
// Instruction decoder
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_decode import cpu_pkg::*; (
	input  logic [`BITS-1:0] instr_word,
	output cpu_instr_t       instr
);

	cpu_opcode_e op;

	// codes 13 and 14 are unassigned
	always_comb begin
		case (instr_word[15:12])
			4'd13, 4'd14: op = OP_NOP;
			default:      op = cpu_opcode_e'(instr_word[15:12]);
		endcase
	end

	always_comb begin
		instr.op = op;
		instr.rd = instr_word[11:8];
		instr.ra = instr_word[7:4];
		instr.rb = (op == OP_OUT) ? instr_word[11:8] : instr_word[3:0]; // out data via port b
		instr.imm8 = instr_word[7:0];
		instr.alu_op = ALU_PASS;
		instr.writes_reg = 1'b0;
		instr.sets_flags = 1'b0;
		instr.is_port = 1'b0;

		case (op)
			OP_LDI: instr.writes_reg = 1'b1;      // immediate through pass
			OP_ADD: instr.alu_op = ALU_ADD;
			OP_SUB: instr.alu_op = ALU_SUB;
			OP_AND: instr.alu_op = ALU_AND;
			OP_OR:  instr.alu_op = ALU_OR;
			OP_XOR: instr.alu_op = ALU_XOR;
			OP_SHR: instr.alu_op = ALU_SHR;
			OP_IN: begin
				instr.writes_reg = 1'b1;
				instr.is_port = 1'b1;
			end
			OP_OUT: instr.is_port = 1'b1;
			default: ;
		endcase

		// alu ops write rd and update flags
		if (instr.alu_op != ALU_PASS) begin
			instr.writes_reg = 1'b1;
			instr.sets_flags = 1'b1;
		end
	end

endmodule

/* hw/cpu_register_file.sv */
// CPU register file
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_register_file (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic [`REGISTER_BITS-1:0] ra_sel,
	input  logic [`REGISTER_BITS-1:0] rb_sel,
	output logic [`BITS-1:0]          ra_data,
	output logic [`BITS-1:0]          rb_data,

	input  logic                      wr_en,
	input  logic [`REGISTER_BITS-1:0] wr_sel,
	input  logic [`BITS-1:0]          wr_data
);

	localparam int NUM_REGS = 2 ** `REGISTER_BITS;

	logic [`BITS-1:0] regs [NUM_REGS];

	// async reads
	assign ra_data = regs[ra_sel];
	assign rb_data = regs[rb_sel];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

/* hw/alu.sv */
// Arithmetic logic unit
`timescale 1ns/1ns
`include "cpu_defs.svh"

module alu import cpu_pkg::*; (
	input  logic [`BITS-1:0] a,
	input  logic [`BITS-1:0] b,
	input  alu_op_e          op,
	output logic [`BITS-1:0] result,
	output alu_flags_t       flags
);

	localparam int MSB = `BITS - 1;

	logic [`BITS:0] sum;    // extra bit is the carry
	logic [`BITS:0] diff;   // extra bit is the borrow

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	always_comb begin
		result = b;
		flags.c = 1'b0;
		flags.v = 1'b0;

		case (op)
			ALU_PASS: result = b;
			ALU_ADD: begin
				result = sum[`BITS-1:0];
				flags.c = sum[`BITS];
				flags.v = (a[MSB] == b[MSB]) && (result[MSB] != a[MSB]);
			end
			ALU_SUB: begin
				result = diff[`BITS-1:0];
				flags.c = diff[`BITS];   // set when a < b unsigned
				flags.v = (a[MSB] != b[MSB]) && (result[MSB] != a[MSB]);
			end
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_SHR: begin
				result = {1'b0, a[`BITS-1:1]};
				flags.c = a[0];          // bit shifted out
			end
			default: result = b;
		endcase

		flags.z = (result == '0);
		flags.s = result[MSB];
	end

endmodule

/* hw/cpu_execute.sv */
// Execute and writeback
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_execute import cpu_pkg::*; (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      instr_valid,
	input  cpu_instr_t                instr,
	input  logic [`BITS-1:0]          ra_data,
	input  logic [`BITS-1:0]          rb_data,

	input  logic [`BITS-1:0]          alu_result,
	input  alu_flags_t                alu_flags,
	output logic [`BITS-1:0]          alu_a,
	output logic [`BITS-1:0]          alu_b,
	output alu_op_e                   alu_op,

	output logic                      wr_en,
	output logic [`REGISTER_BITS-1:0] wr_sel,
	output logic [`BITS-1:0]          wr_data,

	output port_req_t                 port_req,
	input  logic [`BITS-1:0]          port_rd_data,

	output logic                      exec_done,
	output logic                      load_pc,
	output logic [`ADDRESS_BITS-1:0]  new_pc,
	output logic                      halt
);

	alu_flags_t flags;      // from the last alu op
	logic       in_wait;    // in is waiting for port data
	logic       is_in;
	logic       taken;

	assign is_in = instr_valid && (instr.op == OP_IN);

	// operands, ldi passes its immediate on b
	assign alu_a = ra_data;
	assign alu_b = (instr.op == OP_LDI) ? {{(`BITS-8){1'b0}}, instr.imm8} : rb_data;
	assign alu_op = instr.alu_op;

	// in writes back one cycle late, with the port data
	assign wr_en = (instr_valid && instr.writes_reg && !instr.is_port) || in_wait;
	assign wr_sel = instr.rd;
	assign wr_data = in_wait ? port_rd_data : alu_result;

	always_comb begin
		port_req.rd = is_in;
		port_req.wr = instr_valid && (instr.op == OP_OUT);
		port_req.address = ra_data;
		port_req.data = rb_data;     // value of rd for out
	end

	always_comb begin
		case (instr.op)
			OP_JMP:  taken = 1'b1;
			OP_JZ:   taken = flags.z;
			OP_JC:   taken = flags.c;
			default: taken = 1'b0;
		endcase
	end

	assign load_pc = instr_valid && taken;
	assign new_pc = {{(`ADDRESS_BITS-8){1'b0}}, instr.imm8};
	assign exec_done = (instr_valid && !is_in) || in_wait;
	assign halt = instr_valid && (instr.op == OP_HALT);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags <= '0;
			in_wait <= 1'b0;
		end else begin
			in_wait <= is_in;
			if (instr_valid && instr.sets_flags)
				flags <= alu_flags;
		end
	end

endmodule

/* hw/cpu_port_interface.sv */
// I/O port interface
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_port_interface import cpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,

	input  port_req_t                port_req,
	output logic [`BITS-1:0]         port_rd_data,

	output logic [`ADDRESS_BITS-1:0] port_address,
	output logic [`BITS-1:0]         port_out,
	output logic                     port_rd,
	output logic                     port_wr,
	input  logic [`BITS-1:0]         port_in
);

	// strobes last one cycle since the request does
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			port_rd <= 1'b0;
			port_wr <= 1'b0;
		end else begin
			port_rd <= port_req.rd;
			port_wr <= port_req.wr;
		end
	end

	always_ff @(posedge clk) begin
		if (port_req.rd || port_req.wr) begin
			port_address <= port_req.address;
			port_out <= port_req.data;
		end
	end

	assign port_rd_data = port_rd ? port_in : '0;   // device answers in the rd cycle

endmodule

/* hw/cpu_top.sv */
// CPU top level
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,

	output logic [`ADDRESS_BITS-1:0] memory_address,
	input  logic [`BITS-1:0]         memory_in,
	output logic                     memory_valid,
	input  logic                     memory_ready,

	output logic [`ADDRESS_BITS-1:0] port_address,
	input  logic [`BITS-1:0]         port_in,
	output logic [`BITS-1:0]         port_out,
	output logic                     port_rd,
	output logic                     port_wr,

	output logic                     halted
);

	logic                      instr_valid;
	logic [`BITS-1:0]          instr_word;
	cpu_instr_t                instr;
	logic                      exec_done;
	logic                      load_pc;
	logic [`ADDRESS_BITS-1:0]  new_pc;
	logic                      halt;

	logic [`BITS-1:0]          ra_data;
	logic [`BITS-1:0]          rb_data;
	logic                      wr_en;
	logic [`REGISTER_BITS-1:0] wr_sel;
	logic [`BITS-1:0]          wr_data;

	logic [`BITS-1:0]          alu_a;
	logic [`BITS-1:0]          alu_b;
	alu_op_e                   alu_op;
	logic [`BITS-1:0]          alu_result;
	alu_flags_t                alu_flags;

	port_req_t                 port_req;
	logic [`BITS-1:0]          port_rd_data;

	// input side
	cpu_fetch fetch_i (
		.clk, .rst_n,
		.memory_address, .memory_in, .memory_valid, .memory_ready,
		.instr_valid, .instr_word,
		.exec_done, .load_pc, .new_pc, .halt, .halted
	);

	cpu_decode decode_i (.instr_word, .instr);

	cpu_register_file regs_i (
		.clk, .rst_n,
		.ra_sel(instr.ra), .rb_sel(instr.rb), .ra_data, .rb_data,
		.wr_en, .wr_sel, .wr_data
	);

	alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .flags(alu_flags));

	cpu_execute execute_i (
		.clk, .rst_n,
		.instr_valid, .instr, .ra_data, .rb_data,
		.alu_result, .alu_flags, .alu_a, .alu_b, .alu_op,
		.wr_en, .wr_sel, .wr_data,
		.port_req, .port_rd_data,
		.exec_done, .load_pc, .new_pc, .halt
	);

	// output side
	cpu_port_interface port_i (
		.clk, .rst_n,
		.port_req, .port_rd_data,
		.port_address, .port_out, .port_rd, .port_wr, .port_in
	);

endmodule

/* dv/cpu_tb.sv */
// CPU testbench
`timescale 1ns/1ns
`include "cpu_defs.svh"

module cpu_tb import cpu_pkg::*; ();

	logic                     clk;
	logic                     rst_n;
	logic [`ADDRESS_BITS-1:0] memory_address;
	logic [`BITS-1:0]         memory_in;
	logic                     memory_valid;
	logic                     memory_ready;
	logic [`ADDRESS_BITS-1:0] port_address;
	logic [`BITS-1:0]         port_in;
	logic [`BITS-1:0]         port_out;
	logic                     port_rd;
	logic                     port_wr;
	logic                     halted;

	logic [`BITS-1:0]         imem [256];
	logic [`ADDRESS_BITS-1:0] exp_addr [$];
	logic [`BITS-1:0]         exp_data [$];
	logic [31:0]              rng;
	int                       pc_w;
	int                       mem_delay;
	int                       errors;
	int                       wr_count;
	int                       fetch_count;
	bit                       first_req;

	cpu_top cpu_top_i (.*);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	assign port_in = port_address ^ 16'h5a5a;   // port device

	function automatic logic [31:0] next_rand();
		rng ^= rng << 13;
		rng ^= rng >> 17;
		rng ^= rng << 5;
		return rng;
	endfunction

	function automatic logic [15:0] encode(input cpu_opcode_e op, input int rd, ra, rb);
		return {op, 4'(rd), 4'(ra), 4'(rb)};
	endfunction

	function automatic logic [15:0] encode_ldi(input int rd, input int imm);
		return {OP_LDI, 4'(rd), 8'(imm)};
	endfunction

	task automatic emit(input logic [15:0] w);
		imem[pc_w] = w;
		pc_w++;
	endtask

	task automatic clear_mem();
		for (int i = 0; i < 256; i++)
			imem[i] = {4'hd, 4'h0, 8'(i)};   // unused code, runs as nop
		pc_w = 0;
	endtask

	// jump over one ldi/out pair, the second pair runs on both paths
	task automatic branch_case(input cpu_opcode_e op, input logic [7:0] marker);
		emit({op, 4'h0, 8'(pc_w + 3)});
		emit(encode_ldi(4, marker));
		emit(encode(OP_OUT, 4, 15, 0));
		emit(encode_ldi(4, ~marker));
		emit(encode(OP_OUT, 4, 15, 0));
	endtask

	task automatic build_random(input int n);
		logic [31:0] bits;
		int          pick;
		clear_mem();
		for (int i = 0; i < n; i++) begin
			pick = next_rand() % 8;
			bits = next_rand();
			// ldi through shr, or out
			emit({(pick < 7) ? 4'(pick + 1) : OP_OUT, bits[11:0]});
		end
		emit(encode(OP_HALT, 0, 0, 0));
	endtask

	// instruction set model, fills the expected port writes
	function automatic int reference_run();
		logic [`BITS-1:0] r [16];
		logic [`BITS-1:0] w;
		logic [`BITS-1:0] a;
		logic [`BITS-1:0] b;
		logic [`BITS-1:0] res;
		logic [7:0]       pc;
		logic             z;
		logic             c;
		logic             is_alu;
		int               u;
		int               steps;
		for (int i = 0; i < 16; i++)
			r[i] = '0;
		z = 1'b0;
		c = 1'b0;
		pc = '0;
		steps = 0;
		exp_addr.delete();
		exp_data.delete();
		while (steps < 1000) begin
			w = imem[pc];
			a = r[w[7:4]];
			b = r[w[3:0]];
			steps++;
			pc++;
			is_alu = 1'b1;
			case (w[15:12])
				OP_ADD: begin
					u = a + b;
					res = u[15:0];
					c = (u > 65535);
				end
				OP_SUB: begin
					res = a - b;
					c = (a < b);
				end
				OP_AND: begin
					res = a & b;
					c = 1'b0;
				end
				OP_OR: begin
					res = a | b;
					c = 1'b0;
				end
				OP_XOR: begin
					res = a ^ b;
					c = 1'b0;
				end
				OP_SHR: begin
					res = a >> 1;
					c = a[0];
				end
				default: is_alu = 1'b0;
			endcase
			if (is_alu) begin
				z = (res == 0);
				r[w[11:8]] = res;
			end
			case (w[15:12])
				OP_LDI: r[w[11:8]] = {8'h00, w[7:0]};
				OP_IN:  r[w[11:8]] = a ^ 16'h5a5a;
				OP_OUT: begin
					exp_addr.push_back(a);
					exp_data.push_back(r[w[11:8]]);
				end
				OP_JMP: pc = w[7:0];
				OP_JZ:  if (z) pc = w[7:0];
				OP_JC:  if (c) pc = w[7:0];
				OP_HALT: return steps;
				default: ;
			endcase
		end
		return steps;
	endfunction

	task automatic compare_values(input logic [15:0] got, input logic [15:0] exp,
			input string what);
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	// instruction memory, ready after 0 to 3 idle cycles
	always @(posedge clk) begin
		if (!rst_n) begin
			memory_ready <= 1'b0;
		end else if (memory_ready) begin
			memory_ready <= 1'b0;   // word taken at this edge
		end else if (memory_valid) begin
			if (mem_delay == 0) begin
				memory_ready <= 1'b1;
				memory_in <= imem[memory_address[7:0]];
				mem_delay = next_rand() % 4;
			end else begin
				mem_delay--;
			end
		end
	end

	// monitor and compare
	always @(posedge clk) begin
		if (!rst_n) begin
			if (memory_valid || port_rd || port_wr || halted) begin
				errors++;
				$display("error at %0t: outputs active during reset", $time);
			end
		end else begin
			if (memory_valid && first_req) begin
				compare_values(memory_address, 16'h0000, "first fetch address");
				first_req = 1'b0;
			end
			if (memory_valid && memory_ready)
				fetch_count++;
			if (halted && memory_valid) begin
				errors++;
				$display("error at %0t: fetch request after halt", $time);
			end
			if (port_wr) begin
				if (wr_count < exp_addr.size()) begin
					compare_values(port_address, exp_addr[wr_count], "port write address");
					compare_values(port_out, exp_data[wr_count], "port write data");
				end
				wr_count++;
			end
		end
	end

	task automatic run_program(input string name);
		int expected;
		int limit;
		int cycles;
		expected = reference_run();
		limit = 40 * expected + 200;
		cycles = 0;
		@(posedge clk);
		rst_n <= 1'b0;
		repeat (8) @(posedge clk);
		wr_count = 0;
		fetch_count = 0;
		first_req = 1'b1;
		rst_n <= 1'b1;
		while (!halted && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!halted) begin
			errors++;
			$display("timeout: program %s did not halt within %0d cycles", name, limit);
			$display("errors: %0d", errors);
			$display("Checks failed");
			$finish;
		end else begin
			repeat (10) @(negedge clk);   // no fetch may follow the halt
			if (wr_count != exp_addr.size()) begin
				errors++;
				$display("program %s made %0d port writes, expected %0d",
					name, wr_count, exp_addr.size());
			end
			if (fetch_count != expected) begin
				errors++;
				$display("program %s fetched %0d instructions, expected %0d",
					name, fetch_count, expected);
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		memory_ready = 1'b0;
		memory_in = '0;
		rng = 32'd17150;
		mem_delay = 0;
		errors = 0;
		wr_count = 0;
		fetch_count = 0;
		first_req = 1'b1;

		// arithmetic, carry, borrow and overflow
		clear_mem();
		emit(encode_ldi(15, 8'h40));
		emit(encode_ldi(2, 1));
		emit(encode(OP_SUB, 3, 1, 2));   // 0 - 1 borrows
		emit(encode(OP_ADD, 4, 3, 2));   // carry out to zero
		emit(encode(OP_SHR, 5, 3, 0));
		emit(encode(OP_ADD, 6, 5, 2));   // 7fff + 1 overflows
		emit(encode(OP_SUB, 7, 6, 2));   // 8000 - 1 overflows
		emit(encode_ldi(8, 8'ha5));
		emit(encode(OP_AND, 9, 3, 8));
		emit(encode(OP_OR, 10, 6, 8));
		emit(encode(OP_XOR, 11, 10, 3));
		emit(encode(OP_ADD, 12, 3, 3));
		for (int i = 3; i <= 12; i++)
			emit(encode(OP_OUT, i, 15, 0));
		emit(encode(OP_HALT, 0, 0, 0));
		run_program("arithmetic");

		clear_mem();
		emit(encode_ldi(15, 8'h50));
		emit(encode_ldi(1, 1));
		emit(encode_ldi(2, 2));
		emit(encode(OP_SUB, 3, 1, 1));   // z set, c clear
		branch_case(OP_JZ, 8'h11);
		branch_case(OP_JC, 8'h22);
		emit(encode(OP_SUB, 3, 1, 2));   // borrow, z clear
		branch_case(OP_JZ, 8'h33);
		branch_case(OP_JC, 8'h44);
		branch_case(OP_JMP, 8'h55);
		emit(encode(OP_HALT, 0, 0, 0));
		run_program("branches");

		clear_mem();
		emit(encode_ldi(15, 8'h60));
		emit(encode(OP_SUB, 1, 0, 15));  // address ffa0
		emit(encode_ldi(2, 8'h12));
		emit(encode_ldi(3, 8'hc3));
		for (int i = 1; i <= 3; i++) begin
			emit(encode(OP_IN, i + 4, i, 0));
			emit(encode(OP_OUT, i + 4, 15, 0));
		end
		emit(encode(OP_HALT, 0, 0, 0));
		run_program("port reads");

		for (int k = 0; k < 3; k++) begin
			build_random(24);
			run_program($sformatf("random %0d", k));
		end

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* all.f */
+incdir+hw
hw/cpu_pkg.sv
hw/cpu_fetch.sv
hw/cpu_decode.sv
hw/cpu_register_file.sv
hw/alu.sv
hw/cpu_execute.sv
hw/cpu_port_interface.sv
hw/cpu_top.sv
dv/cpu_tb.sv
